// File: build.f
hdl/fetchPkg.sv
hdl/updateSteer.sv
hdl/slotPredictor.sv
hdl/returnStack.sv
hdl/nextPcSelect.sv
hdl/fetchStage1.sv
tests/clockGen.sv
tests/fetchStage1_assert.sv
tests/fetchStage1_tb.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= fetchStage1_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/fetchStage1_tb.sv
`timescale 1ns/1ps
// Fetch stage one testbench

module fetchStage1_tb;

	typedef struct packed
	{
		fetchPkg::updateReq_t upd;      // Training request of the row
		logic                 stall;
		fetchPkg::redirect_t  rec;      // External recovery
		fetchPkg::redirect_t  exc;
		fetchPkg::redirect_t  ex;       // Execute-stage recovery
		fetchPkg::redirect_t  id;       // Decode-stage recovery
		logic                 retId;    // Decode recovery is a return
		logic [31:0]          expPc;    // PC seen while the row is driven
		logic [3:0]           expHit;   // Expected hit per slot, bit 0 is slot 0
		logic [3:0]           expTaken;
	} stimRow_t;

	logic                  clk;
	logic                  reset;
	fetchPkg::updateReq_t  update;
	logic                  stall;
	fetchPkg::redirect_t   recover;
	fetchPkg::redirect_t   exception;
	fetchPkg::redirect_t   recoverEx;
	fetchPkg::redirect_t   recoverId;
	logic                  returnId;
	fetchPkg::pcWord_u     pc;
	fetchPkg::slotLookup_t lookup [fetchPkg::SLOTS];
	stimRow_t              rowQ [$];                 // Stimulus table
	string                 nameQ [$];                // Row names for error lines
	logic [3:0]            hitVec;
	logic [3:0]            takenVec;
	int                    errCount;
	int                    checkCount;
	int                    waitCnt;

	clockGen clkGen (.clk_o(clk), .reset_o(reset));

	fetchStage1 dut_i
	(
		.clk (clk), .reset (reset), .update_i (update), .stall_i (stall),
		.recover_i (recover), .exception_i (exception), .recoverEx_i (recoverEx),
		.recoverId_i (recoverId), .returnId_i (returnId), .pc_o (pc), .lookup_o (lookup)
	);

	function automatic fetchPkg::updateReq_t updateOf(input logic [31:0] addr, target,
		input fetchPkg::ctrlType_e brType, input logic dir);
		return {1'b1, addr, target, brType, dir}; // Field order en, pc, target, type, dir
	endfunction

	function automatic fetchPkg::redirect_t redirectTo(input logic [31:0] addr);
		return {1'b1, addr};
	endfunction

	task automatic addRow(input string name, input fetchPkg::updateReq_t upd, input logic stallIn,
		input fetchPkg::redirect_t rec, exc, ex, id, input logic retId,
		input logic [31:0] expPc, input logic [3:0] expHit, expTaken);
		nameQ.push_back(name);
		rowQ.push_back({upd, stallIn, rec, exc, ex, id, retId, expPc, expHit, expTaken});
	endtask

	task automatic checkValue(input string testName, input string what,
		input logic [31:0] expVal, input logic [31:0] actVal);
		checkCount++;
		if (actVal !== expVal)
		begin
			errCount++;
			$display("MISMATCH %s %s expected %h actual %h", testName, what, expVal, actVal);
		end
	endtask

	task automatic runRows();
		for (int i = 0; i < rowQ.size(); i++)
		begin
			@(posedge clk);
			#1; // Inputs change just after the edge
			update    = rowQ[i].upd;
			stall     = rowQ[i].stall;
			recover   = rowQ[i].rec;
			exception = rowQ[i].exc;
			recoverEx = rowQ[i].ex;
			recoverId = rowQ[i].id;
			returnId  = rowQ[i].retId;
			@(negedge clk); // Lookup and PC have settled by mid cycle
			for (int s = 0; s < fetchPkg::SLOTS; s++)
			begin
				hitVec[s]   = lookup[s].hit;
				takenVec[s] = lookup[s].taken;
			end
			checkValue(nameQ[i], "pc", rowQ[i].expPc, pc.addr);
			checkValue(nameQ[i], "hit", {28'd0, rowQ[i].expHit}, {28'd0, hitVec});
			checkValue(nameQ[i], "taken", {28'd0, rowQ[i].expTaken}, {28'd0, takenVec});
		end
	endtask

	initial
	begin
		errCount   = 0;
		checkCount = 0;
		waitCnt    = 0;
		update     = '0;
		stall      = 1'b1; // Holds PC at zero until the first row
		recover    = '0;
		exception  = '0;
		recoverEx  = '0;
		recoverId  = '0;
		returnId   = 1'b0;
		// Sequential flow and stall
		addRow("reset pc", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'h0, 4'h0, 4'h0);
		addRow("advance", '0, 1'b1, '0, '0, '0, '0, 1'b0, 32'h20, 4'h0, 4'h0);
		addRow("stall hold", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'h20, 4'h0, 4'h0);
		// Jump in slot 2 of bundle 0x40
		addRow("jump install", updateOf(32'h50, 32'h400, fetchPkg::JUMP, 1'b1), 1'b0,
			'0, '0, '0, '0, 1'b0, 32'h40, 4'h0, 4'h0);
		addRow("jump revisit", '0, 1'b0, redirectTo(32'h40), '0, '0, '0, 1'b0, 32'h60, 4'h0, 4'h0);
		addRow("jump taken", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'h40, 4'h4, 4'h4);
		addRow("jump target", '0, 1'b0, redirectTo(32'h58), '0, '0, '0, 1'b0, 32'h400, 4'h0, 4'h0);
		addRow("late entry", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'h58, 4'h0, 4'h0);
		// Conditional branch at 0x88 trained up and back down
		addRow("cond not taken", updateOf(32'h88, 32'h300, fetchPkg::COND, 1'b0), 1'b0,
			'0, '0, '0, '0, 1'b0, 32'h60, 4'h0, 4'h0);
		addRow("cond unseen", updateOf(32'h88, 32'h300, fetchPkg::COND, 1'b1), 1'b0,
			'0, '0, '0, '0, 1'b0, 32'h80, 4'h0, 4'h0);
		addRow("cond revisit", '0, 1'b0, redirectTo(32'h80), '0, '0, '0, 1'b0, 32'ha0, 4'h0, 4'h0);
		addRow("cond weak", updateOf(32'h88, 32'h300, fetchPkg::COND, 1'b1), 1'b0,
			'0, '0, '0, '0, 1'b0, 32'h80, 4'h2, 4'h0);
		addRow("cond revisit 2", '0, 1'b0, redirectTo(32'h80), '0, '0, '0, 1'b0, 32'ha0, 4'h0, 4'h0);
		addRow("cond strong", updateOf(32'h88, 32'h300, fetchPkg::COND, 1'b0), 1'b0,
			'0, '0, '0, '0, 1'b0, 32'h80, 4'h2, 4'h2);
		addRow("cond target", updateOf(32'h88, 32'h300, fetchPkg::COND, 1'b0), 1'b0,
			redirectTo(32'h80), '0, '0, '0, 1'b0, 32'h300, 4'h0, 4'h0);
		addRow("cond sequential", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'h80, 4'h2, 4'h0);
		// Call at 0xc8 ahead of a jump at 0xd8, return at 0x610
		addRow("call install", updateOf(32'hc8, 32'h600, fetchPkg::CALL, 1'b1), 1'b1,
			'0, '0, '0, '0, 1'b0, 32'ha0, 4'h0, 4'h0);
		addRow("jump behind call", updateOf(32'hd8, 32'h700, fetchPkg::JUMP, 1'b1), 1'b1,
			'0, '0, '0, '0, 1'b0, 32'ha0, 4'h0, 4'h0);
		addRow("ret install", updateOf(32'h610, 32'h0, fetchPkg::RET, 1'b1), 1'b0,
			'0, '0, '0, '0, 1'b0, 32'ha0, 4'h0, 4'h0);
		addRow("call wins", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'hc0, 4'ha, 4'ha);
		addRow("ret taken", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'h600, 4'h4, 4'h4);
		addRow("return address", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'hd0, 4'h8, 4'h8);
		// Redirect priority, one source dropped per row
		addRow("all redirects", '0, 1'b0, redirectTo(32'h1000), redirectTo(32'h2000),
			redirectTo(32'h3000), redirectTo(32'h4000), 1'b0, 32'h700, 4'h0, 4'h0);
		addRow("recover wins", '0, 1'b0, '0, redirectTo(32'h2000), redirectTo(32'h3000),
			redirectTo(32'h4000), 1'b0, 32'h1000, 4'h0, 4'h0);
		addRow("exception wins", '0, 1'b0, '0, '0, redirectTo(32'h3000), redirectTo(32'h4000),
			1'b0, 32'h2000, 4'h0, 4'h0);
		addRow("ex wins", '0, 1'b0, '0, '0, '0, redirectTo(32'h4000), 1'b0, 32'h3000, 4'h0, 4'h0);
		addRow("ex stalled", '0, 1'b1, '0, '0, redirectTo(32'h5000), '0, 1'b0, 32'h4000, 4'h0, 4'h0);
		addRow("id stalled", '0, 1'b1, '0, '0, '0, redirectTo(32'h6000), 1'b0, 32'h5000, 4'h0, 4'h0);
		addRow("call again", '0, 1'b0, redirectTo(32'hc0), '0, '0, '0, 1'b0, 32'h5000, 4'h0, 4'h0);
		addRow("push again", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'hc0, 4'ha, 4'ha);
		addRow("id return", '0, 1'b0, '0, '0, '0, redirectTo(32'h7000), 1'b1, 32'h600, 4'h4, 4'h4);
		addRow("ras target", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'hd0, 4'h8, 4'h8);
		addRow("final", '0, 1'b0, '0, '0, '0, '0, 1'b0, 32'h700, 4'h0, 4'h0);
		do
		begin
			@(posedge clk);
			waitCnt++;
		end
		while (reset && waitCnt < 20);
		if (reset)
		begin
			$display("Reset was still high after %0d clock cycles", waitCnt);
			$display("Simulation failed");
		end
		else
		begin
			runRows();
			errCount += dut_i.assertChk.failCount; // Failed assertions count as errors
			$display("Checks run: %0d, errors: %0d", checkCount, errCount);
			if (errCount == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: tests/fetchStage1_assert.sv
`timescale 1ns/1ps
// Fetch stage one assertions

module fetchStage1_assert
(
	input logic                clk,
	input logic                reset,
	input logic                stall_i,
	input fetchPkg::redirect_t recover_i,
	input fetchPkg::redirect_t exception_i,
	input fetchPkg::redirect_t recoverEx_i,
	input fetchPkg::pcWord_u   pc_i,        // Fetch PC of the DUT
	input logic                push_i,      // Stack push strobe
	input logic                pop_i        // Stack pop strobe
);

	logic hardRedirect; // Redirect allowed to move the PC during a stall
	int   failCount;    // Failed assertion count

	initial failCount = 0;

	assign hardRedirect = recover_i.flag || exception_i.flag || recoverEx_i.flag;

	// Every reset cycle leaves the PC at address zero
	assert property (@(posedge clk) reset |=> (pc_i.addr == '0))
		else
		begin
			failCount++;
			$error("PC is not zero after reset");
		end

	assert property (@(posedge clk) disable iff (reset)
		(stall_i && !hardRedirect) |=> $stable(pc_i.addr))
		else
		begin
			failCount++;
			$error("PC moved during a stall without a redirect");
		end

	assert property (@(posedge clk) !(push_i && pop_i)) // One stack operation per cycle
		else
		begin
			failCount++;
			$error("Push and pop raised in the same cycle");
		end

endmodule

bind fetchStage1 fetchStage1_assert assertChk
(
	.clk         (clk),
	.reset       (reset),
	.stall_i     (stall_i),
	.recover_i   (recover_i),
	.exception_i (exception_i),
	.recoverEx_i (recoverEx_i),
	.pc_i        (pc_o),
	.push_i      (rasPush),
	.pop_i       (rasPop)
);

// File: tests/clockGen.sv
`timescale 1ns/1ps
// Testbench clock and reset

module clockGen
(
	output logic clk_o,   // 40 ns period
	output logic reset_o  // High for the first three rising edges
);

	initial clk_o = 1'b0;

	always #20 clk_o = ~clk_o; // Half of the 40 ns period

	initial
	begin
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		#1 reset_o = 1'b0; // Released just after the third edge
	end

endmodule

// File: hdl/fetchStage1.sv
`timescale 1ns/1ps
// Fetch stage one top level

module fetchStage1
(
	input  logic                  clk,
	input  logic                  reset,
	input  fetchPkg::updateReq_t  update_i,                    // In-order predictor training
	input  logic                  stall_i,                     // Back-pressure from decode
	input  fetchPkg::redirect_t   recover_i,                   // External recovery
	input  fetchPkg::redirect_t   exception_i,                 // Exception vector
	input  fetchPkg::redirect_t   recoverEx_i,                 // Execute-stage misprediction
	input  fetchPkg::redirect_t   recoverId_i,                 // Decode-stage misprediction
	input  logic                  returnId_i,                  // ID recovery targets the stack
	output fetchPkg::pcWord_u     pc_o,                        // Current fetch PC
	output fetchPkg::slotLookup_t lookup_o [fetchPkg::SLOTS]   // Per-slot predictions
);

	fetchPkg::slotUpdate_t     slotUpd   [fetchPkg::SLOTS]; // Steered write requests
	fetchPkg::slotLookup_t     rawLookup [fetchPkg::SLOTS]; // Unmasked bank results
	fetchPkg::pcWord_u         fetchPc;                     // PC fanned out to every slot
	logic                      rasPush;                     // Call taken in this bundle
	logic                      rasPop;                      // Return taken or ID return
	logic [fetchPkg::PC_W-1:0] rasPushAddr;                 // Return address to save
	logic [fetchPkg::PC_W-1:0] rasTop;                      // Predicted return address

	updateSteer steer
	(
		.update_i  (update_i),
		.slotUpd_o (slotUpd)
	);

	// One bank per instruction position, all looked up with the same PC
	for (genvar g = 0; g < fetchPkg::SLOTS; g++)
	begin : slotGen
		slotPredictor slotPred
		(
			.clk      (clk),
			.reset    (reset),
			.pc_i     (fetchPc),
			.upd_i    (slotUpd[g]),
			.lookup_o (rawLookup[g])
		);
	end

	returnStack ras
	(
		.clk        (clk),
		.reset      (reset),
		.push_i     (rasPush),
		.pop_i      (rasPop),
		.pushAddr_i (rasPushAddr),
		.top_o      (rasTop)
	);

	nextPcSelect pcSel
	(
		.clk         (clk),
		.reset       (reset),
		.stall_i     (stall_i),
		.recover_i   (recover_i),
		.exception_i (exception_i),
		.recoverEx_i (recoverEx_i),
		.recoverId_i (recoverId_i),
		.returnId_i  (returnId_i),
		.lookup_i    (rawLookup),
		.rasTop_i    (rasTop),
		.pc_o        (fetchPc),
		.lookup_o    (lookup_o),
		.push_o      (rasPush),
		.pop_o       (rasPop),
		.pushAddr_o  (rasPushAddr)
	);

	assign pc_o = fetchPc;

endmodule

// File: hdl/nextPcSelect.sv
`timescale 1ns/1ps
// PC register and next-PC selection

module nextPcSelect
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      stall_i,                      // Freezes PC and stack
	input  fetchPkg::redirect_t       recover_i,                    // Highest priority redirect
	input  fetchPkg::redirect_t       exception_i,
	input  fetchPkg::redirect_t       recoverEx_i,                  // Execute-stage recovery
	input  fetchPkg::redirect_t       recoverId_i,                  // Decode-stage recovery
	input  logic                      returnId_i,                   // ID recovery is a return
	input  fetchPkg::slotLookup_t     lookup_i [fetchPkg::SLOTS],   // Raw slot predictions
	input  logic [fetchPkg::PC_W-1:0] rasTop_i,                     // Current stack top
	output fetchPkg::pcWord_u         pc_o,                         // Fetch PC of this cycle
	output fetchPkg::slotLookup_t     lookup_o [fetchPkg::SLOTS],   // Masked predictions
	output logic                      push_o,                       // Push a return address
	output logic                      pop_o,                        // Pop the stack
	output logic [fetchPkg::PC_W-1:0] pushAddr_o                    // Address to push
);

	fetchPkg::pcWord_u         pcReg;        // Program counter
	fetchPkg::pcWord_u         bundleBase;   // PC with slot and offset cleared
	fetchPkg::pcWord_u         selPc;        // Address of the chosen taken slot
	logic [fetchPkg::PC_W-1:0] seqPc;        // Start of the following bundle
	logic [fetchPkg::PC_W-1:0] nextPc;       // Winner of the priority chain
	logic [fetchPkg::SLOT_W-1:0] selSlot;    // Earliest unmasked taken slot
	logic                      anyTaken;     // Some unmasked slot redirects
	logic                      hardRedirect; // Redirect that overrides a stall
	logic                      pushReq;      // Chosen slot is a call
	logic                      popReq;       // Chosen source consumes the stack top

	// Mask slots ahead of the entry point and put the stack top on returns
	always_comb
	begin
		for (int s = 0; s < fetchPkg::SLOTS; s++)
		begin
			lookup_o[s] = lookup_i[s];
			if (s < pcReg.fields.slot)
			begin
				lookup_o[s].hit   = 1'b0; // Instruction lies before the fetch PC
				lookup_o[s].taken = 1'b0;
			end
			if (lookup_i[s].ctrlType == fetchPkg::RET)
				lookup_o[s].target = rasTop_i;
		end
	end

	// Walk down so the lowest taken slot is the last one kept
	always_comb
	begin
		anyTaken = 1'b0;
		selSlot  = '0;
		for (int s = fetchPkg::SLOTS - 1; s >= 0; s--)
		begin
			if (lookup_o[s].taken)
			begin
				anyTaken = 1'b1;
				selSlot  = s[fetchPkg::SLOT_W-1:0];
			end
		end
	end

	always_comb
	begin
		bundleBase               = pcReg;
		bundleBase.fields.slot   = '0;
		bundleBase.fields.offset = '0;
		selPc                    = bundleBase;
		selPc.fields.slot        = selSlot;                        // Address of the chosen slot
		seqPc                    = bundleBase.addr + fetchPkg::BUNDLE_BYTES;
		hardRedirect = recover_i.flag || exception_i.flag || recoverEx_i.flag;
		pushReq    = 1'b0;
		popReq     = 1'b0;
		pushAddr_o = selPc.addr + fetchPkg::INST_BYTES;      // Return lands after the call
		nextPc     = seqPc;
		if (recover_i.flag)
			nextPc = recover_i.pc;
		else if (exception_i.flag)
			nextPc = exception_i.pc;
		else if (recoverEx_i.flag)
			nextPc = recoverEx_i.pc;
		else if (recoverId_i.flag)
		begin
			nextPc = returnId_i ? rasTop_i : recoverId_i.pc; // Missed return comes off the stack
			popReq = returnId_i;
		end
		else if (anyTaken)
		begin
			nextPc  = lookup_o[selSlot].target;              // Already the stack top for returns
			popReq  = (lookup_o[selSlot].ctrlType == fetchPkg::RET);
			pushReq = (lookup_o[selSlot].ctrlType == fetchPkg::CALL);
		end
	end

	// The stack only moves when the bundle really advances
	assign push_o = pushReq && !stall_i;
	assign pop_o  = popReq && !stall_i;

	always_ff @(posedge clk)
	begin
		if (reset)
			pcReg.addr <= '0;
		else if (hardRedirect || !stall_i) // Late recoveries cannot wait out a stall
			pcReg.addr <= nextPc;
	end

	assign pc_o = pcReg;

endmodule

// File: hdl/returnStack.sv
`timescale 1ns/1ps
// Circular return address stack

module returnStack
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      push_i,      // Call predicted in the fetched bundle
	input  logic                      pop_i,       // Return predicted or ID return recovery
	input  logic [fetchPkg::PC_W-1:0] pushAddr_i,  // Return address of the call
	output logic [fetchPkg::PC_W-1:0] top_o        // Most recent return address
);

	logic [fetchPkg::PC_W-1:0]      stackMem [fetchPkg::RAS_DEPTH]; // Return address storage
	logic [fetchPkg::RAS_PTR_W-1:0] topPtr;                         // Points at the newest entry
	logic [fetchPkg::RAS_PTR_W-1:0] pushPtr;                        // Slot written by a push

	assign pushPtr = topPtr + 1'b1; // Wraps around, so overflow drops the oldest entry

	always_ff @(posedge clk)
	begin
		if (reset)
			topPtr <= '0;
		else if (push_i)
			topPtr <= pushPtr;
		else if (pop_i)
			topPtr <= topPtr - 1'b1; // Underflow wraps and reads stale entries
	end

	always_ff @(posedge clk)
	begin
		if (push_i && !reset)
			stackMem[pushPtr] <= pushAddr_i;
	end

	assign top_o = stackMem[topPtr]; // New top is visible the cycle after a push or pop

endmodule

// File: hdl/slotPredictor.sv
`timescale 1ns/1ps
// Per-slot target bank and counters

module slotPredictor
(
	input  logic                  clk,
	input  logic                  reset,
	input  fetchPkg::pcWord_u     pc_i,      // Fetch PC of the current bundle
	input  fetchPkg::slotUpdate_t upd_i,     // Write request steered to this slot
	output fetchPkg::slotLookup_t lookup_o   // Prediction for this slot position
);

	logic                         validArr  [fetchPkg::BTB_ENTRIES]; // Entry holds a branch
	logic [fetchPkg::TAG_W-1:0]   tagArr    [fetchPkg::BTB_ENTRIES]; // Upper PC bits of the branch
	fetchPkg::ctrlType_e          typeArr   [fetchPkg::BTB_ENTRIES]; // Stored control type
	logic [fetchPkg::PC_W-1:0]    targetArr [fetchPkg::BTB_ENTRIES]; // Stored target address
	logic [1:0]                   ctrArr    [fetchPkg::BTB_ENTRIES]; // Bimodal direction counters
	logic [1:0]                   ctrUpd;                            // Counter being trained
	logic [fetchPkg::INDEX_W-1:0] rdIdx;                             // Lookup entry
	logic                         tagMatch;                          // Valid entry for this PC
	logic                         predTaken;                         // Counter says taken

	assign ctrUpd = ctrArr[upd_i.index];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < fetchPkg::BTB_ENTRIES; i++)
			begin
				validArr[i] <= 1'b0;  // Bank starts empty
				ctrArr[i]   <= 2'b01; // Weakly not taken
			end
		end
		else
		begin
			if (upd_i.btbWrite)
				validArr[upd_i.index] <= 1'b1;
			if (upd_i.bpWrite)
			begin
				// Two-bit counter saturates at both ends
				if (upd_i.dir && (ctrUpd != 2'b11))
					ctrArr[upd_i.index] <= ctrUpd + 2'b01;
				else if (!upd_i.dir && (ctrUpd != 2'b00))
					ctrArr[upd_i.index] <= ctrUpd - 2'b01;
			end
		end
	end

	// Tag, type and target of each written entry
	always_ff @(posedge clk)
	begin
		if (upd_i.btbWrite)
		begin
			tagArr[upd_i.index]    <= upd_i.tag;
			typeArr[upd_i.index]   <= upd_i.brType;
			targetArr[upd_i.index] <= upd_i.target;
		end
	end

	assign rdIdx     = pc_i.fields.index;
	assign tagMatch  = validArr[rdIdx] && (tagArr[rdIdx] == pc_i.fields.tag);
	assign predTaken = ctrArr[rdIdx][1]; // Upper bit set means taken

	always_comb
	begin
		lookup_o.hit      = tagMatch;
		lookup_o.ctrlType = typeArr[rdIdx];
		lookup_o.target   = targetArr[rdIdx];
		// Unconditional transfers ignore the counter
		lookup_o.taken    = tagMatch && ((typeArr[rdIdx] != fetchPkg::COND) || predTaken);
	end

endmodule

// File: hdl/updateSteer.sv
`timescale 1ns/1ps
// Update request steering

module updateSteer
(
	input  fetchPkg::updateReq_t  update_i,                     // In-order training request
	output fetchPkg::slotUpdate_t slotUpd_o [fetchPkg::SLOTS]   // One write request per slot
);

	fetchPkg::pcWord_u updPc;  // Update address seen through the field view
	logic              btbWr;  // Target bank write before slot steering
	logic              bpWr;   // Counter write before slot steering

	assign updPc = update_i.pc;

	// Counters only learn from conditional branches
	assign bpWr = update_i.en && (update_i.brType == fetchPkg::COND);

	// A not-taken conditional never allocates a target entry
	assign btbWr = update_i.en && ((update_i.brType != fetchPkg::COND) || update_i.dir);

	always_comb
	begin
		for (int s = 0; s < fetchPkg::SLOTS; s++)
		begin
			slotUpd_o[s].btbWrite = btbWr && (updPc.fields.slot == s); // Only the named slot writes
			slotUpd_o[s].bpWrite  = bpWr && (updPc.fields.slot == s);
			slotUpd_o[s].index    = updPc.fields.index;                 // Same split as the lookup
			slotUpd_o[s].tag      = updPc.fields.tag;
			slotUpd_o[s].target   = update_i.target;
			slotUpd_o[s].brType   = update_i.brType;
			slotUpd_o[s].dir      = update_i.dir;
		end
	end

endmodule

// File: hdl/fetchPkg.sv
// Fetch stage one shared types

package fetchPkg;

	localparam int PC_W = 32;                                  // Width of a program counter
	localparam int SLOTS = 4;                                  // Instructions fetched per bundle
	localparam int INST_BYTES = 8;                             // Size of one instruction slot
	localparam int BUNDLE_BYTES = SLOTS * INST_BYTES;          // Bytes covered by one bundle
	localparam int BTB_ENTRIES = 16;                           // Entries in each slot bank
	localparam int INDEX_W = $clog2(BTB_ENTRIES);              // Bank index bits
	localparam int SLOT_W = $clog2(SLOTS);                     // Slot number bits
	localparam int OFFSET_W = $clog2(INST_BYTES);              // Byte offset inside a slot
	localparam int TAG_W = PC_W - INDEX_W - SLOT_W - OFFSET_W; // Remaining upper bits
	localparam int RAS_DEPTH = 8;                              // Return stack entries
	localparam int RAS_PTR_W = $clog2(RAS_DEPTH);              // Stack pointer bits

	// Same encoding as the control-transfer queue uses
	typedef enum logic [1:0]
	{
		RET  = 2'd0,
		CALL = 2'd1,
		JUMP = 2'd2,
		COND = 2'd3
	} ctrlType_e;

	typedef struct packed
	{
		logic [TAG_W-1:0]    tag;     // Compared against the stored bank tag
		logic [INDEX_W-1:0]  index;   // Selects the bank entry
		logic [SLOT_W-1:0]   slot;    // Position of the instruction in its bundle
		logic [OFFSET_W-1:0] offset;  // Always zero for aligned instructions
	} pcFields_t;

	typedef union packed
	{
		logic [PC_W-1:0] addr;        // Flat byte address
		pcFields_t       fields;      // Same word split for the banks
	} pcWord_u;

	typedef struct packed
	{
		logic            en;          // Request is valid this cycle
		logic [PC_W-1:0] pc;          // Address of the resolved branch
		logic [PC_W-1:0] target;      // Resolved target address
		ctrlType_e       brType;      // Kind of control transfer
		logic            dir;         // Resolved direction, 1 for taken
	} updateReq_t;

	typedef struct packed
	{
		logic               btbWrite; // Write the target bank entry
		logic               bpWrite;  // Train the direction counter
		logic [INDEX_W-1:0] index;    // Entry to write
		logic [TAG_W-1:0]   tag;      // Tag stored with the entry
		logic [PC_W-1:0]    target;   // Target stored with the entry
		ctrlType_e          brType;   // Type stored with the entry
		logic               dir;      // Counter training direction
	} slotUpdate_t;

	typedef struct packed
	{
		logic            hit;         // Valid entry with a matching tag
		logic            taken;       // Hit and predicted to redirect
		ctrlType_e       ctrlType;    // Type of the stored branch
		logic [PC_W-1:0] target;      // Predicted target address
	} slotLookup_t;

	typedef struct packed
	{
		logic            flag;        // Redirect requested this cycle
		logic [PC_W-1:0] pc;          // Address to continue from
	} redirect_t;

endpackage
